//--- rtl/alu_pkg.sv
`default_nettype none

package alu_pkg;

	// Opcode field in CTRL bits 2:0
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_AND = 3'd2,
		OP_OR  = 3'd3,
		OP_XOR = 3'd4,
		OP_SLL = 3'd5,
		OP_SRA = 3'd6,
		OP_ROR = 3'd7
	} alu_op_t;

	// Shifter select
	typedef enum logic [1:0] {
		SHIFT_SLL = 2'b00,
		SHIFT_SRA = 2'b01,
		SHIFT_ROR = 2'b10
	} shift_mode_t;

	// Word index from bus address bits 3:1
	localparam logic [2:0] REG_OPA    = 3'd0;
	localparam logic [2:0] REG_OPB    = 3'd1;
	localparam logic [2:0] REG_CTRL   = 3'd2;
	localparam logic [2:0] REG_RESULT = 3'd3; // read only
	localparam logic [2:0] REG_STATUS = 3'd4; // read only

	localparam int CTRL_START = 15; // reads back as 0

	// STATUS bits
	localparam int ST_DONE = 0;
	localparam int ST_Z    = 1;
	localparam int ST_N    = 2;
	localparam int ST_V    = 3;

endpackage

`default_nettype wire

//--- rtl/alu_cmd_if.sv
`timescale 1ns/100ps
`default_nettype none

interface alu_cmd_if #(
	parameter int DATA_W = 16
) ();
	import alu_pkg::*;

	// Register block side
	logic              start;
	alu_op_t           op;
	logic [DATA_W-1:0] opa;
	logic [DATA_W-1:0] opb;

	// Core side, held until the next start
	logic              done;
	logic [DATA_W-1:0] result;
	logic              flag_z;
	logic              flag_n;
	logic              flag_v;

	modport regs (
		output start, op, opa, opb,
		input  done, result, flag_z, flag_n, flag_v
	);

	modport core (
		input  start, op, opa, opb,
		output done, result, flag_z, flag_n, flag_v
	);

endinterface

`default_nettype wire

//--- rtl/barrel_shifter.sv
`timescale 1ns/100ps
`default_nettype none

module barrel_shifter #(
	parameter int DATA_W = 16
) (
	input  logic [DATA_W-1:0]         data,
	input  logic [$clog2(DATA_W)-1:0] amount,
	input  alu_pkg::shift_mode_t      mode,
	output logic [DATA_W-1:0]         result
);
	import alu_pkg::*;

	localparam int SH_W = $clog2(DATA_W);

	// stage[0] is the input, stage[SH_W] the shifted value
	logic [SH_W:0][DATA_W-1:0] stage;

	assign stage[0] = data;

	for (genvar s = 0; s < SH_W; s++) begin : g_stage
		localparam int K = 1 << s; // Shift of this stage

		logic [DATA_W-1:0] moved;
		logic              sign;

		assign sign = stage[s][DATA_W-1];

		always_comb begin
			case (mode)
				SHIFT_SRA: moved = {{K{sign}}, stage[s][DATA_W-1:K]};
				SHIFT_ROR: moved = {stage[s][K-1:0], stage[s][DATA_W-1:K]};
				default:   moved = {stage[s][DATA_W-1-K:0], {K{1'b0}}}; // SLL
			endcase
		end

		// Bypass when this bit of the amount is clear
		assign stage[s+1] = amount[s] ? moved : stage[s];
	end

	assign result = stage[SH_W];

endmodule

`default_nettype wire

//--- rtl/alu_core.sv
`timescale 1ns/100ps
`default_nettype none

module alu_core #(
	parameter int DATA_W = 16
) (
	input  logic       clk,
	input  logic       rst,
	alu_cmd_if.core    cmd
);
	import alu_pkg::*;

	localparam int SH_W = $clog2(DATA_W);

	logic              sub;
	logic [DATA_W-1:0] addend;
	logic [DATA_W-1:0] sum;
	logic              ovf;
	shift_mode_t       sh_mode;
	logic [DATA_W-1:0] shifted;
	logic [DATA_W-1:0] alu_out;
	logic              v_next;

	// One adder for both, B inverted plus carry in for subtract
	assign sub    = (cmd.op == OP_SUB);
	assign addend = cmd.opb ^ {DATA_W{sub}};
	assign sum    = cmd.opa + addend + DATA_W'(sub);

	// Operands agree in sign, sum does not
	assign ovf = (cmd.opa[DATA_W-1] == addend[DATA_W-1]) &&
		(sum[DATA_W-1] != cmd.opa[DATA_W-1]);

	always_comb begin
		case (cmd.op)
			OP_SRA:  sh_mode = SHIFT_SRA;
			OP_ROR:  sh_mode = SHIFT_ROR;
			default: sh_mode = SHIFT_SLL;
		endcase
	end

	barrel_shifter #(
		.DATA_W (DATA_W)
	) u_shifter (
		.data   (cmd.opa),
		.amount (cmd.opb[SH_W-1:0]),
		.mode   (sh_mode),
		.result (shifted)
	);

	always_comb begin
		alu_out = sum;
		v_next  = 1'b0;
		case (cmd.op)
			OP_ADD, OP_SUB: begin
				alu_out = sum;
				v_next  = ovf;
			end
			OP_AND: alu_out = cmd.opa & cmd.opb;
			OP_OR:  alu_out = cmd.opa | cmd.opb;
			OP_XOR: alu_out = cmd.opa ^ cmd.opb;
			OP_SLL, OP_SRA, OP_ROR: alu_out = shifted;
			default: alu_out = sum;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cmd.done   <= 1'b0;
			cmd.result <= '0;
			cmd.flag_z <= 1'b0;
			cmd.flag_n <= 1'b0;
			cmd.flag_v <= 1'b0;
		end else begin
			cmd.done <= cmd.start; // Fixed one cycle latency
			if (cmd.start) begin
				cmd.result <= alu_out;
				cmd.flag_z <= (alu_out == '0);
				cmd.flag_n <= alu_out[DATA_W-1];
				cmd.flag_v <= v_next;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/alu_regs.sv
`timescale 1ns/100ps
`default_nettype none

module alu_regs #(
	parameter int DATA_W = 16
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  logic [3:0]        wb_adr,
	input  logic [DATA_W-1:0] wb_dat_i,
	output logic [DATA_W-1:0] wb_dat_o,
	output logic              wb_ack,
	alu_cmd_if.regs           cmd
);
	import alu_pkg::*;

	logic              req;
	logic              wr_en;
	logic [2:0]        idx;
	logic              st_done;
	logic [DATA_W-1:0] status;
	logic [DATA_W-1:0] ctrl_rd;

	assign req   = wb_cyc && wb_stb;
	assign idx   = wb_adr[3:1]; // Word index, byte lane bit ignored
	assign wr_en = req && !wb_ack && wb_we;

	// Single cycle ack, one cycle after the request
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= req && !wb_ack;
		end
	end

	// Writes land as ack rises
	always_ff @(posedge clk) begin
		if (rst) begin
			cmd.opa   <= '0;
			cmd.opb   <= '0;
			cmd.op    <= OP_ADD;
			cmd.start <= 1'b0;
		end else begin
			cmd.start <= wr_en && (idx == REG_CTRL) && wb_dat_i[CTRL_START];
			if (wr_en) begin
				case (idx)
					REG_OPA:  cmd.opa <= wb_dat_i;
					REG_OPB:  cmd.opb <= wb_dat_i;
					REG_CTRL: cmd.op  <= alu_op_t'(wb_dat_i[2:0]);
					default:  ; // RESULT and STATUS are read only
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			st_done <= 1'b0;
		end else if (cmd.start) begin
			st_done <= 1'b0;
		end else if (cmd.done) begin
			st_done <= 1'b1;
		end
	end

	always_comb begin
		status          = '0;
		status[ST_DONE] = st_done;
		status[ST_Z]    = cmd.flag_z;
		status[ST_N]    = cmd.flag_n;
		status[ST_V]    = cmd.flag_v;
	end

	// Start bit always reads 0
	assign ctrl_rd = {{(DATA_W-3){1'b0}}, cmd.op};

	// Address held by the master, so data is valid in the ack cycle
	always_comb begin
		case (idx)
			REG_OPA:    wb_dat_o = cmd.opa;
			REG_OPB:    wb_dat_o = cmd.opb;
			REG_CTRL:   wb_dat_o = ctrl_rd;
			REG_RESULT: wb_dat_o = cmd.result;
			REG_STATUS: wb_dat_o = status;
			default:    wb_dat_o = '0; // Unmapped
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/alu_top.sv
`timescale 1ns/100ps
`default_nettype none

module alu_top #(
	parameter int DATA_W = 16
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  logic [3:0]        wb_adr,
	input  logic [DATA_W-1:0] wb_dat_i,
	output logic [DATA_W-1:0] wb_dat_o,
	output logic              wb_ack
);

	// Command path between register block and core
	alu_cmd_if #(
		.DATA_W (DATA_W)
	) cmd ();

	alu_regs #(
		.DATA_W (DATA_W)
	) u_regs (
		.clk      (clk),
		.rst      (rst),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack   (wb_ack),
		.cmd      (cmd.regs)
	);

	alu_core #(
		.DATA_W (DATA_W)
	) u_core (
		.clk (clk),
		.rst (rst),
		.cmd (cmd.core)
	);

endmodule

`default_nettype wire

//--- dv/alu_properties.sv
`timescale 1ns/100ps
`default_nettype none

module alu_properties (
	input logic clk,
	input logic rst,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input logic start,
	input logic done,
	input logic st_done
);

	// Ack only answers a request seen in the cycle before
	ack_needs_request: assert property (@(posedge clk) disable iff (rst)
		$rose(wb_ack) |-> $past(wb_cyc && wb_stb))
		else $error("wb_ack rose without wb_cyc and wb_stb");

	ack_single_cycle: assert property (@(posedge clk) disable iff (rst)
		wb_ack |=> !wb_ack)
		else $error("wb_ack high for two cycles in a row");

	done_after_start: assert property (@(posedge clk) disable iff (rst)
		start |=> done)
		else $error("done did not follow start");

	done_needs_start: assert property (@(posedge clk) disable iff (rst)
		done |-> $past(start))
		else $error("done without start one cycle before");

	// ST_DONE drops while the new command completes
	start_clears_done: assert property (@(posedge clk) disable iff (rst)
		start |=> !st_done)
		else $error("ST_DONE not cleared by start");

	quiet_in_reset: assert property (@(posedge clk)
		rst |=> (!wb_ack && !start))
		else $error("wb_ack or start high during reset");

endmodule

bind alu_regs alu_properties u_props (
	.clk     (clk),
	.rst     (rst),
	.wb_cyc  (wb_cyc),
	.wb_stb  (wb_stb),
	.wb_ack  (wb_ack),
	.start   (cmd.start),
	.done    (cmd.done),
	.st_done (st_done)
);

`default_nettype wire

//--- dv/tb_alu_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_alu_top;
	import alu_pkg::*;

	localparam int N_DIRECTED = 10;
	localparam int N_RANDOM   = 8;
	localparam int N_OPS      = N_DIRECTED + 5 * N_RANDOM + 3 * 16;
	localparam int N_ACCESS   = 18 + 5 * N_OPS; // Five bus accesses per operation
	localparam int MAX_CYCLES = 40 * N_ACCESS + 200;

	logic        clk;
	logic        rst;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [3:0]  wb_adr;
	logic [15:0] wb_dat_i;
	logic [15:0] wb_dat_o;
	logic        wb_ack;

	integer seed;
	int     errors;
	int     cycles;

	alu_top #(
		.DATA_W (16)
	) uut (
		.clk      (clk),
		.rst      (rst),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack   (wb_ack)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic wait_ack();
		do @(posedge clk); while (!wb_ack);
	endtask

	task automatic write_word(input logic [2:0] idx, input logic [15:0] data);
		@(posedge clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= 1'b1;
		wb_adr   <= {idx, 1'b0};
		wb_dat_i <= data;
		wait_ack();
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic read_word(input logic [2:0] idx, output logic [15:0] data);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we  <= 1'b0;
		wb_adr <= {idx, 1'b0};
		wait_ack();
		data = wb_dat_o; // Value of the ack cycle
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("ERROR: %s read 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	function automatic string reg_name(input logic [2:0] idx);
		case (idx)
			REG_OPA:    return "OPA";
			REG_OPB:    return "OPB";
			REG_CTRL:   return "CTRL";
			REG_RESULT: return "RESULT";
			REG_STATUS: return "STATUS";
			default:    return "UNMAPPED";
		endcase
	endfunction

	function automatic logic [15:0] random_word();
		logic [31:0] r;
		r = $random(seed);
		return r[15:0];
	endfunction

	// Reference model of the operations
	function automatic logic [15:0] expected_result(input alu_op_t op,
		input logic [15:0] a, input logic [15:0] b);
		logic [3:0]  amt;
		logic [31:0] twice;
		amt   = b[3:0];
		twice = {a, a} >> amt;
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_SLL:  return a << amt;
			OP_SRA:  return $unsigned($signed(a) >>> amt);
			default: return twice[15:0]; // ROR
		endcase
	endfunction

	function automatic logic [15:0] expected_status(input alu_op_t op,
		input logic [15:0] a, input logic [15:0] b, input logic [15:0] res);
		logic v;
		v = 1'b0;
		if (op == OP_ADD)
			v = (a[15] == b[15]) && (res[15] != a[15]);
		if (op == OP_SUB)
			v = (a[15] != b[15]) && (res[15] != a[15]);
		return {12'h000, v, res[15], (res == 16'h0000), 1'b1};
	endfunction

	task automatic execute_op(input alu_op_t op, input logic [15:0] a,
		input logic [15:0] b);
		logic [15:0] got;
		logic [15:0] res;
		write_word(REG_OPA, a);
		write_word(REG_OPB, b);
		write_word(REG_CTRL, 16'h8000 | {13'h0000, op});
		res = expected_result(op, a, b);
		read_word(REG_RESULT, got);
		check_value("RESULT", got, res);
		read_word(REG_STATUS, got);
		check_value("STATUS", got, expected_status(op, a, b, res));
	endtask

	task automatic run_random(input alu_op_t op);
		for (int i = 0; i < N_RANDOM; i++) begin
			execute_op(op, random_word(), random_word());
		end
	endtask

	// Every amount, upper bits of B random
	task automatic sweep_shift(input alu_op_t op);
		logic [15:0] a;
		logic [15:0] b;
		for (int k = 0; k < 16; k++) begin
			a = random_word();
			b = random_word();
			b[3:0] = 4'(k);
			if (op == OP_SRA)
				a[15] = b[0]; // Half the values negative
			execute_op(op, a, b);
		end
	endtask

	initial begin
		logic [15:0] got;
		rst      = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = 4'h0;
		wb_dat_i = 16'h0000;
		errors   = 0;
		seed     = 32'h0019a6d9;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		for (int k = 0; k < 6; k++) begin
			read_word(3'(k), got);
			check_value(reg_name(3'(k)), got, 16'h0000);
		end

		write_word(REG_OPA, 16'ha5c3);
		write_word(REG_OPB, 16'h3c5a);
		write_word(REG_CTRL, {13'h0000, OP_XOR});
		read_word(REG_OPA, got);
		check_value("OPA", got, 16'ha5c3);
		read_word(REG_OPB, got);
		check_value("OPB", got, 16'h3c5a);
		read_word(REG_CTRL, got);
		check_value("CTRL", got, {13'h0000, OP_XOR});
		write_word(REG_RESULT, 16'hffff);
		write_word(REG_STATUS, 16'hffff);
		read_word(REG_RESULT, got);
		check_value("RESULT", got, 16'h0000);
		read_word(REG_STATUS, got);
		check_value("STATUS", got, 16'h0000);
		write_word(REG_CTRL, 16'h8000 | {13'h0000, OP_OR});
		read_word(REG_CTRL, got);
		check_value("CTRL", got, {13'h0000, OP_OR});

		execute_op(OP_ADD, 16'h7fff, 16'h0001);
		execute_op(OP_ADD, 16'h8000, 16'h8000);
		execute_op(OP_ADD, 16'hffff, 16'h0001);
		execute_op(OP_ADD, 16'h1234, 16'h4321);
		execute_op(OP_SUB, 16'h8000, 16'h0001);
		execute_op(OP_SUB, 16'h7fff, 16'hffff);
		execute_op(OP_SUB, 16'h5555, 16'h5555);
		execute_op(OP_SUB, 16'h0000, 16'h0001);
		execute_op(OP_AND, 16'h0f0f, 16'hf0f0);
		execute_op(OP_XOR, 16'h9c9c, 16'h9c9c);

		run_random(OP_ADD);
		run_random(OP_SUB);
		run_random(OP_AND);
		run_random(OP_OR);
		run_random(OP_XOR);

		sweep_shift(OP_SLL);
		sweep_shift(OP_SRA);
		sweep_shift(OP_ROR);

		$display("Checks done, %0d errors", errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout, run did not finish within %0d cycles", MAX_CYCLES);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
rtl/alu_pkg.sv
rtl/alu_cmd_if.sv
rtl/barrel_shifter.sv
rtl/alu_core.sv
rtl/alu_regs.sv
rtl/alu_top.sv
dv/alu_properties.sv
dv/tb_alu_top.sv

//--- Makefile
# Verilator simulation of the ALU testbench

VERILATOR ?= verilator
TOP       ?= tb_alu_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TB PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
